// ==== src/int_div_pkg.sv ====
// shared types and constants for the iterative 32-bit divider
// imported by the controller and datapath, and by the checker

package int_div_pkg;

  // -------------------------------------------------------------------------
  // word widths
  // -------------------------------------------------------------------------

  // one operand, quotient or remainder
  typedef logic [31:0] word_t;

  // response word, remainder in the upper half and quotient in the lower half
  typedef logic [63:0] result_t;

  // working register
  // partial remainder in bits 64..32, quotient being built in bits 31..0
  // the divisor register uses the same layout with the divisor at bit 32
  typedef logic [64:0] acc_t;

  // iteration counter, counts 0..31
  typedef logic [4:0] count_t;

  // -------------------------------------------------------------------------
  // function encoding and iteration count
  // -------------------------------------------------------------------------

  // divreq_fn values
  localparam logic DIV_FN_UNSIGNED = 1'b0;
  localparam logic DIV_FN_SIGNED   = 1'b1;

  // one shift-subtract step per quotient bit
  localparam int DIV_ITERATIONS = 32;

  // -------------------------------------------------------------------------
  // controller states
  // -------------------------------------------------------------------------

  // idle waits for a request, calc runs the steps, done holds the response
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } ctrl_state_t;

endpackage

// ==== src/int_div_dpath.sv ====
// datapath of the iterative divider
// holds the remainder/quotient register, the divisor and the operand signs

`timescale 1ns/1ps

module int_div_dpath (
  input  logic                 clk,
  input  logic                 reset,

  // request operands sampled when load is high
  input  logic                 divreq_fn,
  input  int_div_pkg::word_t   divreq_a,
  input  int_div_pkg::word_t   divreq_b,

  // enables from the controller
  input  logic                 load,
  input  logic                 step,

  // remainder in the upper word, quotient in the lower word
  output int_div_pkg::result_t divresp_result
);

  import int_div_pkg::*;

  // -------------------------------------------------------------------------
  // operand normalisation
  // -------------------------------------------------------------------------

  // signed mode of the incoming request
  logic  req_signed;

  // signs of the incoming operands stay zero in unsigned mode
  logic  req_neg_a;
  logic  req_neg_b;

  // magnitudes handed to the unsigned core
  word_t mag_a;
  word_t mag_b;

  assign req_signed = (divreq_fn == DIV_FN_SIGNED);
  assign req_neg_a  = req_signed & divreq_a[31];
  assign req_neg_b  = req_signed & divreq_b[31];

  // two's complement negation for negative signed operands
  assign mag_a = req_neg_a ? word_t'(-divreq_a) : divreq_a;
  assign mag_b = req_neg_b ? word_t'(-divreq_b) : divreq_b;

  // -------------------------------------------------------------------------
  // restoring shift-subtract step
  // -------------------------------------------------------------------------

  // working register and divisor register
  acc_t acc_reg;
  acc_t div_reg;

  // stored function and raw operand signs
  logic fn_reg;
  logic sign_a_reg;
  logic sign_b_reg;

  // one step of the algorithm built combinationally from acc_reg
  acc_t acc_shifted;
  acc_t acc_diff;
  acc_t acc_next;

  assign acc_shifted = acc_reg << 1;
  assign acc_diff    = acc_shifted - div_reg;

  // bit 64 of the difference set means the divisor did not fit
  // restore the shifted value with quotient bit 0, else keep difference with bit 1
  always_comb begin
    if (acc_diff[64]) begin
      acc_next = {acc_shifted[64:1], 1'b0};
    end else begin
      acc_next = {acc_diff[64:1], 1'b1};
    end
  end

  // operands and signs captured on the accepting edge
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg     <= DIV_FN_UNSIGNED;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (load) begin
      fn_reg     <= divreq_fn;
      sign_a_reg <= divreq_a[31];
      sign_b_reg <= divreq_b[31];
    end
  end

  // working register loads on accept and shifts once per calc cycle
  always_ff @(posedge clk) begin
    if (load) begin
      // dividend magnitude zero-extended so the partial remainder starts at zero
      acc_reg <= {33'b0, mag_a};
      // divisor magnitude aligned with the remainder half
      div_reg <= {1'b0, mag_b, 32'b0};
    end else if (step) begin
      acc_reg <= acc_next;
    end
  end

  // -------------------------------------------------------------------------
  // result sign fix-up
  // -------------------------------------------------------------------------

  // signs only count in signed mode
  logic  neg_a;
  logic  neg_b;
  logic  quot_neg;
  logic  rem_neg;

  // magnitudes after the last step
  word_t quot_mag;
  word_t rem_mag;

  // signed results
  word_t quot_out;
  word_t rem_out;

  assign neg_a = (fn_reg == DIV_FN_SIGNED) & sign_a_reg;
  assign neg_b = (fn_reg == DIV_FN_SIGNED) & sign_b_reg;

  // quotient negative when the signs differ
  assign quot_neg = neg_a ^ neg_b;
  // remainder follows the dividend
  assign rem_neg  = neg_a;

  // remainder never exceeds the divisor, so bit 64 is clear at the end
  assign quot_mag = acc_reg[31:0];
  assign rem_mag  = acc_reg[63:32];

  assign quot_out = quot_neg ? word_t'(-quot_mag) : quot_mag;
  assign rem_out  = rem_neg ? word_t'(-rem_mag) : rem_mag;

  // stable while the controller sits in done
  assign divresp_result = {rem_out, quot_out};

endmodule

// ==== src/int_div_ctrl.sv ====
// controller of the iterative divider
// sequences idle, 32 calc cycles and done, and drives the handshake and enables

`timescale 1ns/1ps

module int_div_ctrl (
  input  logic clk,
  input  logic reset,

  // request and response handshake
  input  logic divreq_val,
  input  logic divresp_rdy,
  output logic divreq_rdy,
  output logic divresp_val,

  // datapath enables
  output logic load,
  output logic step
);

  import int_div_pkg::*;

  // -------------------------------------------------------------------------
  // state and iteration counter
  // -------------------------------------------------------------------------

  ctrl_state_t state;
  count_t      count;

  // counter value of the final step
  localparam count_t LAST_COUNT = count_t'(DIV_ITERATIONS - 1);

  // handshake events
  logic req_fire;
  logic resp_fire;
  logic last_step;

  assign req_fire  = divreq_val & divreq_rdy;
  assign resp_fire = divresp_val & divresp_rdy;
  assign last_step = (count == LAST_COUNT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          // operands are captured on this same edge
          if (req_fire) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // one step per cycle, leave after the 32nd
          if (last_step) begin
            state <= DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          // hold the response until the consumer takes it
          if (resp_fire) begin
            state <= IDLE;
            count <= '0;
          end
        end
        default: begin
          state <= IDLE;
          count <= '0;
        end
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // outputs, decoded from the state
  // -------------------------------------------------------------------------

  // ready depends on the state only
  assign divreq_rdy  = (state == IDLE);
  assign divresp_val = (state == DONE);

  // load on the accepting edge, step through all of calc
  assign load = req_fire;
  assign step = (state == CALC);

endmodule

// ==== src/int_div_iterative.sv ====
// top level of the iterative 32-bit divider
// one request at a time over valid/ready, 32 cycles from accept to response

`timescale 1ns/1ps

module int_div_iterative (
  input  logic                 clk,
  input  logic                 reset,

  // request port
  input  logic                 divreq_fn,
  input  int_div_pkg::word_t   divreq_a,
  input  int_div_pkg::word_t   divreq_b,
  input  logic                 divreq_val,
  output logic                 divreq_rdy,

  // response port
  output int_div_pkg::result_t divresp_result,
  output logic                 divresp_val,
  input  logic                 divresp_rdy
);

  // -------------------------------------------------------------------------
  // controller to datapath
  // -------------------------------------------------------------------------

  // capture operands on the accepting edge
  logic load;
  // one shift-subtract per cycle
  logic step;

  // state machine and iteration counter
  int_div_ctrl i_ctrl (
    .clk         (clk),
    .reset       (reset),
    .divreq_val  (divreq_val),
    .divresp_rdy (divresp_rdy),
    .divreq_rdy  (divreq_rdy),
    .divresp_val (divresp_val),
    .load        (load),
    .step        (step)
  );

  // operand registers, restoring step and sign fix-up
  int_div_dpath i_dpath (
    .clk            (clk),
    .reset          (reset),
    .divreq_fn      (divreq_fn),
    .divreq_a       (divreq_a),
    .divreq_b       (divreq_b),
    .load           (load),
    .step           (step),
    .divresp_result (divresp_result)
  );

endmodule

// ==== verification/int_div_checker.sv ====
// checker for the iterative divider testbench
// watches the DUT ports, models the expected results and timing, counts errors

`timescale 1ns/1ps

module int_div_checker (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 divreq_fn,
  input  int_div_pkg::word_t   divreq_a,
  input  int_div_pkg::word_t   divreq_b,
  input  logic                 divreq_val,
  input  logic                 divreq_rdy,
  input  int_div_pkg::result_t divresp_result,
  input  logic                 divresp_val,
  input  logic                 divresp_rdy,
  input  logic [127:0]         test_name,
  output int                   error_count,
  output int                   resp_count
);

  import int_div_pkg::*;

  // valid is first seen high on the edge after the 32nd step edge
  localparam int RISE_EDGES = DIV_ITERATIONS + 1;

  // expected responses and their test names, in request order
  result_t      exp_q[$];
  logic [127:0] name_q[$];

  int           cycle;
  int           accept_cycle;
  logic         busy;
  logic         wait_rise;
  logic         hold_active;
  logic         reset_q;
  result_t      held_result;
  result_t      expected;
  logic [127:0] name;

  // reference model built on the simulator's own division operators
  function automatic result_t model_div(input logic fn, input word_t a, input word_t b);
    longint sa;
    longint sb;
    longint q;
    longint r;
    word_t  qw;
    word_t  rw;
    if (b == 32'd0) begin
      // all ones quotient, dividend as remainder
      qw = 32'hFFFF_FFFF;
      rw = a;
      if (fn == DIV_FN_SIGNED && a[31]) begin
        qw = 32'd1;
      end
    end else if (fn == DIV_FN_SIGNED) begin
      // 64-bit math, so min by minus one wraps to 0x80000000 on truncation
      sa = longint'($signed(a));
      sb = longint'($signed(b));
      q  = sa / sb;
      r  = sa % sb;
      qw = q[31:0];
      rw = r[31:0];
    end else begin
      qw = a / b;
      rw = a % b;
    end
    return {rw, qw};
  endfunction

  task automatic flag_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      busy        = 1'b0;
      wait_rise   = 1'b0;
      hold_active = 1'b0;
    end else begin
      // first edge out of reset, outputs must show an idle divider
      if (reset_q && (divreq_rdy !== 1'b1 || divresp_val !== 1'b0)) begin
        flag_error("outputs not idle right after reset");
      end
      // ready must stay low from acceptance until the response transfer
      if (busy && divreq_rdy) begin
        flag_error("divreq_rdy high while a division is in flight");
      end
      if (divresp_val && !busy) begin
        flag_error("divresp_val high with no request outstanding");
      end
      if (wait_rise && divresp_val) begin
        wait_rise = 1'b0;
        if (cycle - accept_cycle != RISE_EDGES) begin
          flag_error($sformatf("response latency wrong, valid seen %0d edges after accept",
                               cycle - accept_cycle));
        end
      end
      // a stalled response must hold its valid and its value
      if (hold_active) begin
        if (!divresp_val) begin
          flag_error("divresp_val dropped before divresp_rdy was high");
        end else if (divresp_result !== held_result) begin
          flag_error("divresp_result changed during a response stall");
        end
      end
      hold_active = divresp_val && !divresp_rdy;
      held_result = divresp_result;
      if (divresp_val && divresp_rdy) begin
        if (exp_q.size() == 0) begin
          flag_error("response transfer with no expected result queued");
        end else begin
          expected = exp_q.pop_front();
          name     = name_q.pop_front();
          if (divresp_result !== expected) begin
            $display("[FAIL] %0s: expected %h, actual %h", name, expected, divresp_result);
            error_count++;
          end
        end
        resp_count++;
        busy = 1'b0;
      end
      if (divreq_val && divreq_rdy) begin
        exp_q.push_back(model_div(divreq_fn, divreq_a, divreq_b));
        name_q.push_back(test_name);
        accept_cycle = cycle;
        busy         = 1'b1;
        wait_rise    = 1'b1;
      end
    end
    reset_q = reset;
    cycle++;
  end

endmodule

// ==== verification/int_div_tb.sv ====
// testbench for the iterative divider
// applies a table of fixed and random divisions with response stalls and idle gaps

`timescale 1ns/1ps

module int_div_tb;

  import int_div_pkg::*;

  localparam int     CLK_PERIOD   = 40;
  localparam int     RESET_CYCLES = 5;
  localparam int     NUM_FIXED    = 16;
  localparam int     NUM_RANDOM   = 24;
  localparam int     NUM_ROWS     = NUM_FIXED + NUM_RANDOM;
  localparam int     MAX_STALL    = 5;
  localparam int     MAX_GAP      = 3;
  localparam int     SEED         = 69424;
  // each row costs one division plus the worst stall and gap, and the sum is doubled
  localparam longint WATCHDOG_NS  =
    2 * NUM_ROWS * (33 + MAX_STALL + MAX_GAP + 4) * CLK_PERIOD;

  logic         clk;
  logic         reset;
  logic         divreq_fn;
  word_t        divreq_a;
  word_t        divreq_b;
  logic         divreq_val;
  logic         divreq_rdy;
  result_t      divresp_result;
  logic         divresp_val;
  logic         divresp_rdy;
  logic [127:0] test_name;
  int           chk_errors;
  int           resp_count;
  int           tb_errors;

  // ---------------------------------------------------------------------------
  // stimulus table
  // ---------------------------------------------------------------------------

  string row_name[NUM_ROWS];
  logic  row_fn[NUM_ROWS];
  word_t row_a[NUM_ROWS];
  word_t row_b[NUM_ROWS];
  int    row_stall[NUM_ROWS];
  int    row_gap[NUM_ROWS];
  int    n_rows;

  int_div_iterative i_dut (
    .clk            (clk),
    .reset          (reset),
    .divreq_fn      (divreq_fn),
    .divreq_a       (divreq_a),
    .divreq_b       (divreq_b),
    .divreq_val     (divreq_val),
    .divreq_rdy     (divreq_rdy),
    .divresp_result (divresp_result),
    .divresp_val    (divresp_val),
    .divresp_rdy    (divresp_rdy)
  );

  int_div_checker i_checker (
    .clk            (clk),
    .reset          (reset),
    .divreq_fn      (divreq_fn),
    .divreq_a       (divreq_a),
    .divreq_b       (divreq_b),
    .divreq_val     (divreq_val),
    .divreq_rdy     (divreq_rdy),
    .divresp_result (divresp_result),
    .divresp_val    (divresp_val),
    .divresp_rdy    (divresp_rdy),
    .test_name      (test_name),
    .error_count    (chk_errors),
    .resp_count     (resp_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // test name as right-aligned ascii for the checker port
  function automatic logic [127:0] pack_name(input string s);
    logic [127:0] bits;
    int           i;
    bits = '0;
    for (i = 0; i < s.len() && i < 16; i++) begin
      bits = {bits[119:0], s[i]};
    end
    return bits;
  endfunction

  task automatic add_row(input string name, input logic fn, input word_t a, input word_t b,
                         input int stall, input int gap);
    row_name[n_rows]  = name;
    row_fn[n_rows]    = fn;
    row_a[n_rows]     = a;
    row_b[n_rows]     = b;
    row_stall[n_rows] = stall;
    row_gap[n_rows]   = gap;
    n_rows++;
  endtask

  task automatic build_table();
    word_t r;
    int    i;
    add_row("u_basic", DIV_FN_UNSIGNED, 100, 7, 0, 0);
    add_row("u_small_a", DIV_FN_UNSIGNED, 3, 10, 1, 1);
    add_row("u_top_bits", DIV_FN_UNSIGNED, 32'hFFFF_FFFF, 32'h8000_0000, 0, 0);
    add_row("u_top_a", DIV_FN_UNSIGNED, 32'hDEAD_BEEF, 3, 2, 0);
    add_row("u_by_one", DIV_FN_UNSIGNED, 32'h8000_0001, 1, 0, 2);
    add_row("u_equal", DIV_FN_UNSIGNED, 32'h1234_5678, 32'h1234_5678, 0, 0);
    // all four sign combinations
    add_row("s_pos_pos", DIV_FN_SIGNED, 100, 7, 0, 0);
    add_row("s_neg_pos", DIV_FN_SIGNED, -100, 7, 3, 0);
    add_row("s_pos_neg", DIV_FN_SIGNED, 100, -7, 0, 1);
    add_row("s_neg_neg", DIV_FN_SIGNED, -100, -7, 0, 0);
    add_row("s_min_by_neg1", DIV_FN_SIGNED, 32'h8000_0000, 32'hFFFF_FFFF, 1, 0);
    add_row("s_min_by_one", DIV_FN_SIGNED, 32'h8000_0000, 1, 0, 0);
    // division by zero in both modes
    add_row("u_div_zero", DIV_FN_UNSIGNED, 32'h89AB_CDEF, 0, 0, 0);
    add_row("s_div_zero_pos", DIV_FN_SIGNED, 12345, 0, 0, 0);
    add_row("s_div_zero_neg", DIV_FN_SIGNED, -12345, 0, 2, 0);
    add_row("u_long_stall", DIV_FN_UNSIGNED, 32'hFFFF_FFFF, 32'h0000_FFFF, MAX_STALL, MAX_GAP);
    // random rows shift the divisor down to spread its magnitude
    for (i = 0; i < NUM_RANDOM; i++) begin
      r = $urandom;
      add_row($sformatf("rand_%0d", i), r[0], $urandom, $urandom >> ($urandom % 32),
              $urandom % 4, $urandom % 3);
    end
  endtask

  // one request, then the response with its stall, then the idle gap
  task automatic apply_row(input int idx);
    divreq_fn  <= row_fn[idx];
    divreq_a   <= row_a[idx];
    divreq_b   <= row_b[idx];
    divreq_val <= 1'b1;
    test_name  <= pack_name(row_name[idx]);
    do @(posedge clk); while (!divreq_rdy);
    divreq_val  <= 1'b0;
    // with no stall the response is taken in its first valid cycle
    divresp_rdy <= (row_stall[idx] == 0);
    do @(posedge clk); while (!divresp_val);
    if (row_stall[idx] > 0) begin
      // the first valid cycle already counted as one stall cycle
      repeat (row_stall[idx] - 1) @(posedge clk);
      divresp_rdy <= 1'b1;
      @(posedge clk);
    end
    divresp_rdy <= 1'b0;
    repeat (row_gap[idx]) @(posedge clk);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run hung waiting on the DUT", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    divreq_fn   = DIV_FN_UNSIGNED;
    divreq_a    = '0;
    divreq_b    = '0;
    divreq_val  = 1'b0;
    divresp_rdy = 1'b0;
    test_name   = '0;
    n_rows      = 0;
    tb_errors   = 0;
    void'($urandom(SEED));
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < n_rows; i++) begin
      apply_row(i);
    end
    repeat (4) @(posedge clk);
    if (resp_count != n_rows) begin
      $display("ERROR: got %0d responses for %0d requests", resp_count, n_rows);
      tb_errors++;
    end
    $display("errors: checker %0d, testbench %0d, responses %0d of %0d",
             chk_errors, tb_errors, resp_count, n_rows);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
src/int_div_pkg.sv
src/int_div_dpath.sv
src/int_div_ctrl.sv
src/int_div_iterative.sv
verification/int_div_checker.sv
verification/int_div_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the divider testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module int_div_tb \
  -o int_div_sim || { echo "verilator build failed"; exit 1; }

./obj_dir/int_div_sim > sim.log 2>&1 || echo "simulator returned a non-zero status"

cat sim.log

grep -qx "ALL TESTS PASSED" sim.log && echo "simulation result: pass" \
  || { echo "simulation result: fail"; exit 1; }
